// File: src/vic_timing_pkg.sv
package vic_timing_pkg;

    // ----------------------------------------
    // chip variants and raster geometry
    // ----------------------------------------

    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0,
        CHIP_6567R56A = 2'd1,
        CHIP_6569     = 2'd2
    } chip_e;

    // pixel position within a line
    typedef logic [9:0] raster_x_t;
    typedef logic [8:0] raster_line_t;
    // phi cycle within a line, raster_x / 8
    typedef logic [6:0] cycle_num_t;

    typedef struct packed {
        raster_x_t    x_max;
        raster_line_t y_max;
    } chip_limits_t;

    // last pixel and last line for each chip
    function automatic chip_limits_t chip_limits(chip_e chip);
        chip_limits_t lim;
        case (chip)
            CHIP_6567R8: begin
                // 65 cycles, 263 lines
                lim.x_max = 10'd519;
                lim.y_max = 9'd262;
            end
            CHIP_6567R56A: begin
                // 64 cycles, 262 lines
                lim.x_max = 10'd511;
                lim.y_max = 9'd261;
            end
            default: begin
                // PAL, 63 cycles, 312 lines
                lim.x_max = 10'd503;
                lim.y_max = 9'd311;
            end
        endcase
        return lim;
    endfunction

    // ----------------------------------------
    // phase indices and dma windows
    // ----------------------------------------

    // cpu bus sampled here during phi high
    localparam int PHASE_DAV = 10;
    // raster compare fires here during phi low
    localparam int PHASE_IRQ = 8;

    localparam int FIRST_DMA_LINE = 48;
    localparam int LAST_DMA_LINE  = 248;

    // ba low window for character fetches
    localparam int BA_FIRST_CYCLE = 12;
    localparam int BA_LAST_CYCLE  = 54;

endpackage

// File: src/vic_reg_pkg.sv
package vic_reg_pkg;

    // ----------------------------------------
    // register addresses
    // ----------------------------------------

    localparam logic [5:0] REG_CTRL1  = 6'h11;
    localparam logic [5:0] REG_RASTER = 6'h12;
    localparam logic [5:0] REG_IRQ    = 6'h19;
    localparam logic [5:0] REG_IRQ_EN = 6'h1a;

    // $d011 layout
    typedef struct packed {
        logic       rst8;
        logic       ecm;
        logic       bmm;
        logic       den;
        logic       rsel;
        logic [2:0] yscroll;
    } ctrl1_view_t;

    // $d019 / $d01a layout
    typedef struct packed {
        logic       irq_any;
        logic [2:0] unused;
        logic       ilp;
        logic       immc;
        logic       imbc;
        logic       irst;
    } irq_view_t;

    // one data byte, decoded per register
    typedef union packed {
        ctrl1_view_t ctrl1;
        irq_view_t   irq;
    } reg_data_u;

    // ----------------------------------------
    // shared control and timing bundles
    // ----------------------------------------

    typedef struct packed {
        logic       den;
        logic [2:0] yscroll;
        logic [8:0] raster_cmp;
        logic       erst;
        // one tick pulse, write of 1 to $d019 bit 0
        logic       irst_clr;
    } vic_ctrl_t;

    typedef struct packed {
        logic        phi;
        // last tick of each pixel
        logic        dot_rise;
        // one-hot tick within a phi half cycle
        logic [15:0] phase;
    } phase_t;

endpackage

// File: src/vic_phase_gen.sv
`timescale 1ns/100ps

module vic_phase_gen import vic_reg_pkg::*; (
    input  logic   clk_dot4x,
    input  logic   rst,
    output phase_t phase_o
);

    logic [3:0]  dot_sr;
    logic [31:0] phi_sr;
    logic [15:0] phase_sr;

    // pixel strobe, four ticks per pixel
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dot_sr <= 4'b0001;
        end else begin
            dot_sr <= {dot_sr[2:0], dot_sr[3]};
        end
    end

    // phi pattern, 16 ticks low then 16 high
    // bit 31 is the output so reset starts low
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phi_sr <= 32'h0000_ffff;
        end else begin
            phi_sr <= {phi_sr[30:0], phi_sr[31]};
        end
    end

    // phase[0] lines up with each phi edge
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase_sr <= 16'h0001;
        end else begin
            phase_sr <= {phase_sr[14:0], phase_sr[15]};
        end
    end

    assign phase_o.phi      = phi_sr[31];
    assign phase_o.dot_rise = dot_sr[3];
    assign phase_o.phase    = phase_sr;

    a_phase_onehot: assert property (@(posedge clk_dot4x) disable iff (rst)
        $onehot(phase_sr));

endmodule

// File: src/vic_raster.sv
`timescale 1ns/100ps

module vic_raster import vic_timing_pkg::*; import vic_reg_pkg::*; #(
    parameter chip_e CHIP = CHIP_6569
) (
    input  logic         clk_dot4x,
    input  logic         rst,
    input  phase_t       phase_i,
    output raster_x_t    raster_x_o,
    output cycle_num_t   cycle_num_o,
    output raster_line_t raster_line_o,
    output raster_line_t raster_line_d_o
);

    localparam chip_limits_t LIM = chip_limits(CHIP);

    raster_x_t    raster_x;
    raster_line_t raster_line;
    raster_line_t raster_line_d;

    // ----------------------------------------
    // pixel and line counters
    // ----------------------------------------

    // strobe is the last tick of a pixel
    // so x reaches a multiple of 8 on phase[0]
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x    <= '0;
            raster_line <= '0;
        end else if (phase_i.dot_rise) begin
            if (raster_x == LIM.x_max) begin
                raster_x <= '0;
                // wrap after the last line of the frame
                if (raster_line == LIM.y_max) begin
                    raster_line <= '0;
                end else begin
                    raster_line <= raster_line + 9'd1;
                end
            end else begin
                raster_x <= raster_x + 10'd1;
            end
        end
    end

    // delayed line, taken at the start of phi high
    // used for the irq compare and for readback
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_line_d <= '0;
        end else if (phase_i.phi && phase_i.phase[0]) begin
            raster_line_d <= raster_line;
        end
    end

    assign raster_x_o      = raster_x;
    assign cycle_num_o     = raster_x[9:3];
    assign raster_line_o   = raster_line;
    assign raster_line_d_o = raster_line_d;

    a_x_in_range: assert property (@(posedge clk_dot4x) disable iff (rst)
        raster_x <= LIM.x_max);

endmodule

// File: src/vic_registers.sv
`timescale 1ns/100ps

module vic_registers import vic_timing_pkg::*; import vic_reg_pkg::*; (
    input  logic         clk_dot4x,
    input  logic         rst,
    input  phase_t       phase_i,
    input  logic         ce_i,
    input  logic         rw_i,
    input  logic [5:0]   adi_i,
    input  logic [7:0]   dbi_i,
    input  raster_line_t raster_line_d_i,
    input  logic         irst_i,
    input  logic         irq_i,
    output vic_ctrl_t    ctrl_o,
    output logic [7:0]   dbo_o
);

    reg_data_u  ctrl1_q;
    logic [8:0] raster_cmp_q;
    logic       erst_q;
    logic       irst_clr_q;
    logic [7:0] dbo_q;

    logic       access;
    reg_data_u  wr_u;
    reg_data_u  rd_u;

    // one access per phi cycle at the dav tick
    assign access = ~ce_i && phase_i.phi && phase_i.phase[PHASE_DAV];
    assign wr_u   = dbi_i;

    // ----------------------------------------
    // cpu writes
    // ----------------------------------------

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ctrl1_q      <= '0;
            raster_cmp_q <= '0;
            erst_q       <= 1'b0;
            irst_clr_q   <= 1'b0;
        end else begin
            irst_clr_q <= 1'b0;
            if (access && !rw_i) begin
                case (adi_i)
                    REG_CTRL1: begin
                        ctrl1_q <= wr_u;
                        // bit 7 is compare bit 8
                        raster_cmp_q[8] <= wr_u.ctrl1.rst8;
                    end
                    REG_RASTER: raster_cmp_q[7:0] <= dbi_i;
                    // latch bits are cleared by writing 1
                    REG_IRQ:    irst_clr_q <= wr_u.irq.irst;
                    REG_IRQ_EN: erst_q <= wr_u.irq.irst;
                    default: ;
                endcase
            end
        end
    end

    // ----------------------------------------
    // cpu reads
    // ----------------------------------------

    // unused bits read as 1
    always_comb begin
        rd_u = 8'hff;
        case (adi_i)
            REG_CTRL1: begin
                rd_u = ctrl1_q;
                // top bit shows the current line, not the compare
                rd_u.ctrl1.rst8 = raster_line_d_i[8];
            end
            REG_RASTER: rd_u = raster_line_d_i[7:0];
            REG_IRQ: begin
                rd_u.irq.irq_any = irq_i;
                rd_u.irq.unused  = 3'b111;
                rd_u.irq.ilp     = 1'b0;
                rd_u.irq.immc    = 1'b0;
                rd_u.irq.imbc    = 1'b0;
                rd_u.irq.irst    = irst_i;
            end
            REG_IRQ_EN: begin
                rd_u.irq.ilp  = 1'b0;
                rd_u.irq.immc = 1'b0;
                rd_u.irq.imbc = 1'b0;
                rd_u.irq.irst = erst_q;
            end
            default: ;
        endcase
    end

    // read data holds until the next read
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dbo_q <= '0;
        end else if (access && rw_i) begin
            dbo_q <= rd_u;
        end
    end

    assign dbo_o = dbo_q;

    assign ctrl_o.den        = ctrl1_q.ctrl1.den;
    assign ctrl_o.yscroll    = ctrl1_q.ctrl1.yscroll;
    assign ctrl_o.raster_cmp = raster_cmp_q;
    assign ctrl_o.erst       = erst_q;
    assign ctrl_o.irst_clr   = irst_clr_q;

endmodule

// File: src/vic_raster_irq.sv
`timescale 1ns/100ps

module vic_raster_irq import vic_timing_pkg::*; import vic_reg_pkg::*; (
    input  logic         clk_dot4x,
    input  logic         rst,
    input  phase_t       phase_i,
    input  raster_line_t raster_line_d_i,
    input  vic_ctrl_t    ctrl_i,
    output logic         irst_o,
    output logic         irq_o
);

    raster_line_t cmp_d;
    logic         triggered;
    logic         irst;
    logic         fire_tick;

    // compare value lags one tick, in step with raster_line_d
    always_ff @(posedge clk_dot4x) begin
        cmp_d <= ctrl_i.raster_cmp;
    end

    assign fire_tick = ~phase_i.phi && phase_i.phase[PHASE_IRQ];

    // once per match, re-armed when the line moves off the compare
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irst      <= 1'b0;
            triggered <= 1'b0;
        end else begin
            if (raster_line_d_i == cmp_d) begin
                if (fire_tick && !triggered) begin
                    triggered <= 1'b1;
                    irst      <= 1'b1;
                end
            end else begin
                triggered <= 1'b0;
            end
            // cpu clear wins over a same-tick set
            if (ctrl_i.irst_clr) begin
                irst <= 1'b0;
            end
        end
    end

    // latch runs even with erst low
    assign irst_o = irst;
    assign irq_o  = irst & ctrl_i.erst;

    a_irq_needs_erst: assert property (@(posedge clk_dot4x) disable iff (rst)
        !ctrl_i.erst |-> !irq_o);

endmodule

// File: src/vic_bus_request.sv
`timescale 1ns/100ps

module vic_bus_request import vic_timing_pkg::*; import vic_reg_pkg::*; (
    input  logic         clk_dot4x,
    input  logic         rst,
    input  phase_t       phase_i,
    input  cycle_num_t   cycle_num_i,
    input  raster_line_t raster_line_i,
    input  raster_line_t raster_line_d_i,
    input  vic_ctrl_t    ctrl_i,
    output logic         ba_o,
    output logic         aec_o
);

    logic allow_bad_lines;
    logic allow_nxt;
    logic badline;
    logic in_dma_lines;
    logic ba_window;
    logic ba1, ba2, ba3;
    logic phi_hold;

    // ----------------------------------------
    // badline detection
    // ----------------------------------------

    // den counts anywhere on line 48, including its last cycle
    // line_d catches the end, line at cycle 0 the start
    always_comb begin
        allow_nxt = allow_bad_lines;
        if (ctrl_i.den &&
                ((raster_line_i == raster_line_t'(FIRST_DMA_LINE) && cycle_num_i == '0) ||
                 raster_line_d_i == raster_line_t'(FIRST_DMA_LINE))) begin
            allow_nxt = 1'b1;
        end
        if (raster_line_i == raster_line_t'(LAST_DMA_LINE)) begin
            allow_nxt = 1'b0;
        end
    end

    assign in_dma_lines = raster_line_i >= raster_line_t'(FIRST_DMA_LINE) &&
                          raster_line_i <  raster_line_t'(LAST_DMA_LINE);

    // evaluated at phase[1] of phi low, once cycle_num is settled
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad_lines <= 1'b0;
            badline         <= 1'b0;
        end else if (~phase_i.phi && phase_i.phase[1]) begin
            allow_bad_lines <= allow_nxt;
            badline <= (raster_line_i[2:0] == ctrl_i.yscroll) && allow_nxt && in_dma_lines;
        end
    end

    // ----------------------------------------
    // ba and aec
    // ----------------------------------------

    assign ba_window = cycle_num_i >= cycle_num_t'(BA_FIRST_CYCLE) &&
                       cycle_num_i <= cycle_num_t'(BA_LAST_CYCLE);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_o <= 1'b1;
        end else begin
            ba_o <= ~(badline && ba_window);
        end
    end

    // ba history over three phi cycles, taken at the end of phi high
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba1 <= 1'b1;
            ba2 <= 1'b1;
            ba3 <= 1'b1;
        end else if (phase_i.phi && phase_i.phase[15]) begin
            ba1 <= ba_o;
            ba2 <= ba1 | ba_o;
            ba3 <= ba2 | ba_o;
        end
    end

    // aec rises one tick after phi and falls with it
    assign phi_hold = phase_i.phi && !phase_i.phase[15];

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            aec_o <= 1'b0;
        end else begin
            aec_o <= ba_o ? phi_hold : (ba3 & phi_hold);
        end
    end

    a_aec_in_phi_high: assert property (@(posedge clk_dot4x) disable iff (rst)
        aec_o |-> phase_i.phi);

endmodule

// File: src/vic_top.sv
`timescale 1ns/100ps

module vic_top import vic_timing_pkg::*; import vic_reg_pkg::*; #(
    parameter chip_e CHIP = CHIP_6569
) (
    input  logic       clk_dot4x,
    input  logic       rst,
    input  logic       ce_i,
    input  logic       rw_i,
    input  logic [5:0] adi_i,
    input  logic [7:0] dbi_i,
    output logic       phi_o,
    output logic       irq_o,
    output logic       ba_o,
    output logic       aec_o,
    output logic [7:0] dbo_o
);

    phase_t       phase;
    cycle_num_t   cycle_num;
    raster_line_t raster_line;
    raster_line_t raster_line_d;
    vic_ctrl_t    ctrl;
    logic         irst;

    assign phi_o = phase.phi;

    vic_phase_gen u_phase_gen (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_o   (phase)
    );

    // x position is only consumed through cycle_num in this core
    vic_raster #(
        .CHIP (CHIP)
    ) u_raster (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .phase_i         (phase),
        .raster_x_o      (),
        .cycle_num_o     (cycle_num),
        .raster_line_o   (raster_line),
        .raster_line_d_o (raster_line_d)
    );

    vic_registers u_registers (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .phase_i         (phase),
        .ce_i            (ce_i),
        .rw_i            (rw_i),
        .adi_i           (adi_i),
        .dbi_i           (dbi_i),
        .raster_line_d_i (raster_line_d),
        .irst_i          (irst),
        .irq_i           (irq_o),
        .ctrl_o          (ctrl),
        .dbo_o           (dbo_o)
    );

    vic_raster_irq u_raster_irq (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .phase_i         (phase),
        .raster_line_d_i (raster_line_d),
        .ctrl_i          (ctrl),
        .irst_o          (irst),
        .irq_o           (irq_o)
    );

    vic_bus_request u_bus_request (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .phase_i         (phase),
        .cycle_num_i     (cycle_num),
        .raster_line_i   (raster_line),
        .raster_line_d_i (raster_line_d),
        .ctrl_i          (ctrl),
        .ba_o            (ba_o),
        .aec_o           (aec_o)
    );

endmodule

// File: dv/tb_vic.sv
`timescale 1ns/100ps

module tb_vic import vic_timing_pkg::*; import vic_reg_pkg::*; ();

    // PAL geometry as seen from outside the chip
    localparam int TICKS_PER_LINE = 2016;
    localparam int CYC_PER_LINE   = 63;
    localparam int LINES          = 312;

    logic       clk_dot4x;
    logic       rst;
    logic       ce_i;
    logic       rw_i;
    logic [5:0] adi_i;
    logic [7:0] dbi_i;
    logic       phi_o;
    logic       irq_o;
    logic       ba_o;
    logic       aec_o;
    logic [7:0] dbo_o;

    integer seed;
    int     rise_cnt;
    int     tick_cnt;
    logic   phi_q;
    int     errors;
    int     test_err;
    int     tests_run;
    int     tests_ok;

    vic_top #(
        .CHIP (CHIP_6569)
    ) DUT (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .ce_i      (ce_i),
        .rw_i      (rw_i),
        .adi_i     (adi_i),
        .dbi_i     (dbi_i),
        .phi_o     (phi_o),
        .irq_o     (irq_o),
        .ba_o      (ba_o),
        .aec_o     (aec_o),
        .dbo_o     (dbo_o)
    );

    always #2 clk_dot4x = ~clk_dot4x;

    // ----------------------------------------
    // line model, one line per 63 phi rises
    // ----------------------------------------

    always @(posedge clk_dot4x) begin
        if (rst) begin
            rise_cnt <= 0;
            tick_cnt <= 0;
            phi_q    <= 1'b0;
        end else begin
            tick_cnt <= tick_cnt + 1;
            phi_q    <= phi_o;
            if (phi_o && !phi_q) begin
                rise_cnt <= rise_cnt + 1;
            end
        end
    end

    function automatic int model_line();
        if (rise_cnt == 0) begin
            return 0;
        end
        return ((rise_cnt - 1) / CYC_PER_LINE) % LINES;
    endfunction

    // within one line, wrapping at the frame end
    function automatic bit line_close(int a, int b);
        int d;
        d = (a - b + LINES) % LINES;
        return (d <= 1) || (d == LINES - 1);
    endfunction

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic wait_phi(input logic level);
        int n;
        n = 0;
        while (phi_o !== level) begin
            @(negedge clk_dot4x);
            n++;
            if (n > 64) begin
                abort_run("phi level");
            end
        end
    endtask

    // one phi cycle with ce low, then one idle cycle
    task automatic cpu_access(input logic rw, input logic [5:0] addr,
                              input logic [7:0] data, output logic [7:0] rd);
        wait_phi(1'b1);
        wait_phi(1'b0);
        ce_i  = 1'b0;
        rw_i  = rw;
        adi_i = addr;
        dbi_i = data;
        repeat (32) @(negedge clk_dot4x);
        ce_i = 1'b1;
        rw_i = 1'b1;
        rd   = dbo_o;
        repeat (32) @(negedge clk_dot4x);
    endtask

    task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
        logic [7:0] unused_rd;
        cpu_access(1'b0, addr, data, unused_rd);
    endtask

    task automatic read_reg(input logic [5:0] addr, output logic [7:0] rd);
        cpu_access(1'b1, addr, 8'h00, rd);
    endtask

    task automatic wait_irq_rise(input int limit);
        int n;
        n = 0;
        while (irq_o !== 1'b1) begin
            @(negedge clk_dot4x);
            n++;
            if (n > limit) begin
                abort_run("irq_o to rise");
            end
        end
    endtask

    task automatic wait_line_zero();
        int n;
        n = 0;
        while (model_line() != 0) begin
            @(negedge clk_dot4x);
            n++;
            if (n > 2 * LINES * TICKS_PER_LINE) begin
                abort_run("start of frame");
            end
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        errors += test_err;
        if (test_err == 0) begin
            tests_ok++;
            $display("test %s ok", name);
        end else begin
            $display("test %s failed with %0d errors", name, test_err);
        end
        test_err = 0;
    endtask

    initial begin
        logic [7:0] rd;
        logic [7:0] v;
        logic [2:0] ys;
        int         c;
        int         t0;
        int         run;
        int         lvl_err;
        int         rises_since;
        int         hi_ticks;
        bit         seen [LINES];
        bit         expect_bl [LINES];
        bit         prev_phi;
        int         l;

        seed      = 30062;
        errors    = 0;
        test_err  = 0;
        tests_run = 0;
        tests_ok  = 0;
        clk_dot4x = 1'b0;
        rst       = 1'b1;
        ce_i      = 1'b1;
        rw_i      = 1'b1;
        adi_i     = '0;
        dbi_i     = '0;
        repeat (10) @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        rst = 1'b0;

        // ----------------------------------------
        // 1. phi rate
        // ----------------------------------------
        wait_phi(1'b0);
        wait_phi(1'b1);
        // the current sample is the first high tick
        run = 1;
        prev_phi = 1'b1;
        repeat (200 * 32) begin
            @(negedge clk_dot4x);
            if (aec_o && !phi_o) begin
                $display("aec_o high while phi_o low");
                test_err++;
            end
            if (phi_o != prev_phi) begin
                if (run != 16) begin
                    $display("Fail phi_o half period: got %h expected %h", run, 16);
                    test_err++;
                end
                run = 0;
            end
            run++;
            prev_phi = phi_o;
        end
        end_test("phi_rate");

        // ----------------------------------------
        // 2. register readback
        // ----------------------------------------
        repeat (8) begin
            v = $random(seed);
            write_reg(REG_CTRL1, {1'b0, v[6:0]});
            read_reg(REG_CTRL1, rd);
            if (rd[6:0] != v[6:0]) begin
                $display("Fail dbo_o $d011: got %h expected %h", rd[6:0], v[6:0]);
                test_err++;
            end
            write_reg(REG_IRQ_EN, v);
            read_reg(REG_IRQ_EN, rd);
            if (rd != (8'hf0 | v[0])) begin
                $display("Fail dbo_o $d01a: got %h expected %h", rd, 8'hf0 | v[0]);
                test_err++;
            end
            read_reg(REG_RASTER, rd);
            if (!line_close(model_line() & 8'hff, rd) && !line_close(model_line(), rd)) begin
                $display("Fail dbo_o $d012: got %h expected %h", rd, model_line() & 8'hff);
                test_err++;
            end
        end
        end_test("register_readback");

        // ----------------------------------------
        // 3. raster irq
        // ----------------------------------------
        repeat (3) begin
            c = 20 + ($random(seed) & 255);
            if (line_close(c, model_line()) || line_close(c + 2, model_line())) begin
                c = c + 20;
            end
            write_reg(REG_IRQ_EN, 8'h00);
            write_reg(REG_RASTER, c[7:0]);
            write_reg(REG_CTRL1, {c[8], 7'h03});
            write_reg(REG_IRQ, 8'h01);
            write_reg(REG_IRQ_EN, 8'h01);
            wait_irq_rise(2 * LINES * TICKS_PER_LINE);
            t0 = tick_cnt;
            if (!line_close(model_line(), c)) begin
                $display("Fail irq_o line: got %h expected %h", model_line(), c);
                test_err++;
            end
            write_reg(REG_IRQ, 8'h01);
            if (irq_o) begin
                $display("irq_o still high after clearing irst");
                test_err++;
            end
            wait_irq_rise(2 * LINES * TICKS_PER_LINE);
            if ((tick_cnt - t0) < (LINES - 1) * TICKS_PER_LINE) begin
                $display("irq_o rose again before the next frame");
                test_err++;
            end
            if (!line_close(model_line(), c)) begin
                $display("Fail irq_o line: got %h expected %h", model_line(), c);
                test_err++;
            end
            write_reg(REG_IRQ, 8'h01);
        end
        // latch still runs with the enable off
        write_reg(REG_IRQ_EN, 8'h00);
        write_reg(REG_IRQ, 8'h01);
        repeat ((LINES + 1) * TICKS_PER_LINE) begin
            @(negedge clk_dot4x);
            if (irq_o) begin
                $display("irq_o high while erst is cleared");
                test_err++;
            end
        end
        read_reg(REG_IRQ, rd);
        if (rd != 8'h71) begin
            $display("Fail dbo_o $d019: got %h expected %h", rd, 8'h71);
            test_err++;
        end
        end_test("raster_irq");

        // ----------------------------------------
        // 4. badlines, 5. ba/aec in the same frame
        // ----------------------------------------
        ys = $random(seed);
        write_reg(REG_CTRL1, 8'h18 | ys);
        wait_line_zero();
        lvl_err = 0;
        rises_since = 0;
        hi_ticks = 0;
        for (l = 0; l < LINES; l++) begin
            seen[l] = 1'b0;
            expect_bl[l] = (l >= 48) && (l < 248) && ((l & 7) == ys);
        end
        repeat (LINES * TICKS_PER_LINE) begin
            @(negedge clk_dot4x);
            hi_ticks = phi_o ? hi_ticks + 1 : 0;
            if (!ba_o) begin
                seen[model_line()] = 1'b1;
                if (hi_ticks == 1) begin
                    rises_since++;
                end
            end else begin
                rises_since = 0;
            end
            if (!ba_o && rises_since >= 4) begin
                if (aec_o) begin
                    $display("Fail aec_o during ba low: got %h expected %h", aec_o, 1'b0);
                    lvl_err++;
                end
            end else if (hi_ticks != 1 && aec_o != phi_o) begin
                $display("Fail aec_o: got %h expected %h", aec_o, phi_o);
                lvl_err++;
            end
        end
        for (l = 1; l < LINES - 1; l++) begin
            if (seen[l] && !(expect_bl[l - 1] || expect_bl[l] || expect_bl[l + 1])) begin
                $display("ba_o fell on line %0d which is no badline", l);
                test_err++;
            end
            if (expect_bl[l] && !(seen[l - 1] || seen[l] || seen[l + 1])) begin
                $display("ba_o stayed high on badline %0d", l);
                test_err++;
            end
        end
        // no bus request at all with den cleared
        write_reg(REG_CTRL1, {5'b00000, ys});
        wait_line_zero();
        repeat (LINES * TICKS_PER_LINE) begin
            @(negedge clk_dot4x);
            if (!ba_o) begin
                $display("ba_o low while den is cleared");
                test_err++;
            end
        end
        end_test("badlines");
        test_err = lvl_err;
        end_test("ba_aec");

        $display("tests %0d, passed %0d, errors %0d", tests_run, tests_ok, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
src/vic_timing_pkg.sv
src/vic_reg_pkg.sv
src/vic_phase_gen.sv
src/vic_raster.sv
src/vic_registers.sv
src/vic_raster_irq.sv
src/vic_bus_request.sv
src/vic_top.sv
dv/tb_vic.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_vic -Mdir obj_dir -f files.f

run: compile
	./obj_dir/Vtb_vic > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
